//--- Bender.yml
package:
  name: lc3b_core

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/lc3b_types.sv
      - verilog/instr_receiver.sv
      - verilog/cpu_control.sv
      - verilog/regfile.sv
      - verilog/issue_stage.sv
      - verilog/execute_stage.sv
      - verilog/writeback_sender.sv
      - verilog/lc3b_core.sv
  - target: simulation
    files:
      - testbench/tb_lc3b_core.sv

//--- src.f
+incdir+verilog
verilog/lc3b_types.sv
verilog/instr_receiver.sv
verilog/cpu_control.sv
verilog/regfile.sv
verilog/issue_stage.sv
verilog/execute_stage.sv
verilog/writeback_sender.sv
verilog/lc3b_core.sv
testbench/tb_lc3b_core.sv

//--- testbench/tb_lc3b_core.sv
module tb_lc3b_core;

    import lc3b_types::*;

    localparam int ACK_TIMEOUT   = 200;  // cycles per handshake phase
    localparam int DRAIN_TIMEOUT = 2000;

    logic       clk;
    logic       arst_n;
    logic       in_req;
    lc3b_word   in_instr;
    lc3b_word   in_pc;
    logic       in_ack;
    logic       out_req;
    logic       out_ack;
    lc3b_reg    out_dest;
    lc3b_word   out_value;
    logic [2:0] out_cc;

    integer      seed;
    lc3b_word    model_regs [8];
    logic [21:0] expected_q [$];   // {dest, value, cc} in program order
    int          pending;
    lc3b_reg     head_dest;
    lc3b_word    head_value;
    logic [2:0]  head_cc;

    lc3b_core dut (
        .clk      (clk),
        .arst_n   (arst_n),
        .in_req   (in_req),
        .in_instr (in_instr),
        .in_pc    (in_pc),
        .in_ack   (in_ack),
        .out_req  (out_req),
        .out_ack  (out_ack),
        .out_dest (out_dest),
        .out_value(out_value),
        .out_cc   (out_cc)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input lc3b_word got, input lc3b_word exp);
        abort_run($sformatf("ERROR at time %0t: %s is %0h, expected %0h",
                            $time, name, got, exp));
    endtask

    task automatic refresh_head();
        pending = expected_q.size();
        if (pending > 0) begin
            {head_dest, head_value, head_cc} = expected_q[0];
        end
    endtask

    function automatic lc3b_word reg_form(lc3b_opcode op, lc3b_reg dr, lc3b_reg sa, lc3b_reg sb);
        return {op, dr, sa, 3'b000, sb};
    endfunction

    function automatic lc3b_word imm_form(lc3b_opcode op, lc3b_reg dr, lc3b_reg sa,
                                          logic [4:0] imm);
        return {op, dr, sa, 1'b1, imm};
    endfunction

    function automatic lc3b_word not_form(lc3b_reg dr, lc3b_reg sa);
        return {op_not, dr, sa, 6'b111111};
    endfunction

    // mode is {a, d}: 00 sll, 01 srl, 11 sra
    function automatic lc3b_word shift_form(lc3b_reg dr, lc3b_reg sa, logic [1:0] mode,
                                            logic [3:0] amt);
        return {op_shf, dr, sa, mode, amt};
    endfunction

    function automatic lc3b_word lea_form(lc3b_reg dr, logic [8:0] off);
        return {op_lea, dr, off};
    endfunction

    // lc-3b semantics, applied to the register model in issue order
    task automatic model_instr(input lc3b_word instr, input lc3b_word pc, output logic writes,
                               output lc3b_reg dest, output lc3b_word value,
                               output logic [2:0] cc);
        lc3b_word a;
        lc3b_word b;
        a      = model_regs[instr[8:6]];
        b      = instr[5] ? {{11{instr[4]}}, instr[4:0]} : model_regs[instr[2:0]];
        writes = 1'b1;
        dest   = instr[11:9];
        case (instr[15:12])
            4'h1: value = a + b;
            4'h5: value = a & b;
            4'h9: value = ~a;
            4'hd: begin
                if (!instr[4]) value = a << instr[3:0];
                else if (!instr[5]) value = a >> instr[3:0];
                else value = $signed(a) >>> instr[3:0];  // sign fill
            end
            4'he: value = pc + {{6{instr[8]}}, instr[8:0], 1'b0};
            default: begin
                writes = 1'b0;  // accepted, no result
                value  = '0;
            end
        endcase
        cc = value[15] ? 3'b100 : ((value == '0) ? 3'b010 : 3'b001);
        if (writes) model_regs[dest] = value;
    endtask

    task automatic send_instr(input lc3b_word instr, input lc3b_word pc);
        int         cycles;
        logic       writes;
        lc3b_reg    dest;
        lc3b_word   value;
        logic [2:0] cc;
        model_instr(instr, pc, writes, dest, value, cc);
        if (writes) begin
            expected_q.push_back({dest, value, cc});
            refresh_head();
        end
        in_instr = instr;
        in_pc    = pc;
        in_req   = 1'b1;
        cycles   = 0;
        while (!in_ack) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > ACK_TIMEOUT) abort_run("timeout while waiting for in_ack to rise");
        end
        in_req = 1'b0;
        cycles = 0;
        while (in_ack) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > ACK_TIMEOUT) abort_run("timeout while waiting for in_ack to fall");
        end
    endtask

    // output sink with random ack delay
    initial begin
        int delay;
        int cycles;
        out_ack = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            if (out_req && !out_ack) begin
                delay = $unsigned($random(seed)) % 6;
                repeat (delay) begin
                    @(posedge clk);
                    #1;
                end
                out_ack = 1'b1;
                cycles  = 0;
                while (out_req) begin
                    @(posedge clk);
                    #1;
                    cycles++;
                    if (cycles > ACK_TIMEOUT) abort_run("timeout while waiting for out_req to fall");
                end
                out_ack = 1'b0;
                if (expected_q.size() > 0) void'(expected_q.pop_front());
                refresh_head();
            end
        end
    end

    chk_no_extra: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(out_req) |-> pending > 0)
        else abort_run("out_req rose with no result expected");

    chk_dest: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(out_req) |-> out_dest == head_dest)
        else report_mismatch("out_dest", $sampled(out_dest), $sampled(head_dest));

    chk_value: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(out_req) |-> out_value == head_value)
        else report_mismatch("out_value", $sampled(out_value), $sampled(head_value));

    chk_cc: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(out_req) |-> out_cc == head_cc)
        else report_mismatch("out_cc", $sampled(out_cc), $sampled(head_cc));

    chk_in_ack: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(in_ack) |-> $past(in_req))
        else abort_run("in_ack rose while in_req was low");

    chk_out_hold: assert property (@(posedge clk) disable iff (!arst_n)
        out_req && !out_ack |=> out_req && $stable(out_dest) && $stable(out_value) &&
                                $stable(out_cc))
        else abort_run("out_req dropped or its data changed before out_ack");

    initial begin
        lc3b_word word;
        int       pick;
        int       cycles;
        seed     = 81996;
        arst_n   = 1'b0;
        in_req   = 1'b0;
        in_instr = '0;
        in_pc    = '0;
        pending  = 0;
        for (int r = 0; r < 8; r++) model_regs[r] = '0;
        refresh_head();
        repeat (5) @(posedge clk);
        #1;
        arst_n = 1'b1;

        send_instr(imm_form(op_add, 3'd1, 3'd0, 5'd7), 16'h3000);     // r1 = 7
        send_instr(imm_form(op_add, 3'd2, 3'd0, 5'h1d), 16'h3002);    // r2 = -3
        send_instr(reg_form(op_add, 3'd3, 3'd1, 3'd2), 16'h3004);     // depends on both
        send_instr(imm_form(op_and, 3'd4, 3'd3, 5'd0), 16'h3006);     // zero
        send_instr(reg_form(op_and, 3'd5, 3'd2, 3'd1), 16'h3008);
        send_instr(not_form(3'd6, 3'd0), 16'h300a);                   // ffff
        send_instr(shift_form(3'd7, 3'd6, 2'b01, 4'd1), 16'h300c);    // 7fff
        send_instr(imm_form(op_add, 3'd7, 3'd7, 5'd1), 16'h300e);     // signed overflow
        send_instr(imm_form(op_add, 3'd6, 3'd6, 5'd1), 16'h3010);     // wraps to 0
        send_instr(shift_form(3'd1, 3'd7, 2'b11, 4'd3), 16'h3012);
        send_instr(shift_form(3'd2, 3'd7, 2'b01, 4'd15), 16'h3014);
        send_instr(shift_form(3'd3, 3'd5, 2'b00, 4'd12), 16'h3016);
        send_instr(not_form(3'd4, 3'd3), 16'h3018);
        send_instr(lea_form(3'd5, 9'h1f0), 16'h3020);                 // negative offset
        send_instr(lea_form(3'd0, 9'h000), 16'h0000);                 // z from lea
        send_instr({op_br, 12'hfff}, 16'h3022);
        send_instr({op_jmp, 12'h1c0}, 16'h3024);
        send_instr({op_ldr, 12'h283}, 16'h3026);
        send_instr({op_str, 12'h283}, 16'h3028);
        send_instr({op_rti, 12'h000}, 16'h302a);
        send_instr({op_trap, 12'h025}, 16'h302c);
        send_instr(reg_form(op_add, 3'd1, 3'd1, 3'd5), 16'h302e);     // after the drops

        // random mix, mostly subset opcodes, plenty of dependencies
        for (int i = 0; i < 80; i++) begin
            word = $random(seed);
            pick = $unsigned($random(seed)) % 8;
            case (pick)
                0: word[15:12] = op_add;
                1: word[15:12] = op_and;
                2: word[15:12] = op_not;
                3: word[15:12] = op_shf;
                4: word[15:12] = op_lea;
                default: ;  // any opcode
            endcase
            send_instr(word, lc3b_word'($random(seed)));
        end

        cycles = 0;
        while (pending > 0 && cycles < DRAIN_TIMEOUT) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        repeat (10) begin
            @(posedge clk);
            #1;
        end
        if (pending == 0 && !out_req) begin
            $display("No errors");
            $finish;
        end else begin
            abort_run("results still outstanding when the run ended");
        end
    end

endmodule : tb_lc3b_core

//--- verilog/cpu_control.sv
module cpu_control (
    input  lc3b_types::lc3b_opcode     opcode,
    input  logic                       ir_4,
    input  logic                       ir_5,
    output lc3b_types::lc3b_aluop      aluop,
    output lc3b_types::lc3b_alumux_sel alumux_sel,
    output lc3b_types::lc3b_wbmux_sel  wbmux_sel,
    output logic                       load_regfile,
    output logic                       load_cc,
    output logic                       uses_src2
);

    import lc3b_types::*;

    always_comb begin : decode
        aluop        = alu_pass;
        alumux_sel   = sel_src2;
        wbmux_sel    = sel_alu_out;
        load_regfile = 1'b0;
        load_cc      = 1'b0;
        uses_src2    = 1'b0;

        case (opcode)
            op_add, op_and: begin
                aluop        = (opcode == op_add) ? alu_add : alu_and;
                load_regfile = 1'b1;
                load_cc      = 1'b1;
                if (ir_5) begin
                    alumux_sel = sel_imm5;   // immediate form
                end else begin
                    alumux_sel = sel_src2;
                    uses_src2  = 1'b1;       // only the register form reads sr2
                end
            end
            op_not: begin
                aluop        = alu_not;
                load_regfile = 1'b1;
                load_cc      = 1'b1;
            end
            op_shf: begin
                case ({ir_4, ir_5})
                    2'b10:   aluop = alu_srl;
                    2'b11:   aluop = alu_sra;
                    default: aluop = alu_sll;  // ir_4 low is always left
                endcase
                alumux_sel   = sel_imm4;       // amount in ir[3:0]
                load_regfile = 1'b1;
                load_cc      = 1'b1;
            end
            op_lea: begin
                wbmux_sel    = sel_pc_plus_off;
                load_regfile = 1'b1;
                load_cc      = 1'b1;
            end
            // branches, jumps, memory ops and trap write nothing here
            default: ;
        endcase
    end

endmodule : cpu_control

//--- verilog/execute_stage.sv
module execute_stage (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       ex_valid,
    input  lc3b_types::lc3b_aluop      ex_aluop,
    input  lc3b_types::lc3b_alumux_sel ex_alumux_sel,
    input  lc3b_types::lc3b_wbmux_sel  ex_wbmux_sel,
    input  logic                       ex_load_cc,
    input  lc3b_types::lc3b_reg        ex_dest,
    input  lc3b_types::lc3b_word       ex_src1,
    input  lc3b_types::lc3b_word       ex_src2,
    input  lc3b_types::lc3b_word       ex_imm,
    input  lc3b_types::lc3b_word       ex_pc_plus_off,
    output logic                       ex_stall,
    output logic                       wb_valid,
    output lc3b_types::lc3b_reg        wb_dest,
    output lc3b_types::lc3b_word       wb_value,
    output logic [2:0]                 wb_cc,
    input  logic                       wb_stall
);

    import lc3b_types::*;

    lc3b_word   opb;
    lc3b_word   alu_out;
    lc3b_word   result;
    logic [3:0] shamt;
    logic [2:0] cc;

    always_comb begin : operand_select
        case (ex_alumux_sel)
            sel_imm4: opb = lc3b_word'(ex_imm[3:0]);  // zero extended
            sel_imm5: opb = ex_imm;
            default:  opb = ex_src2;
        endcase
    end

    assign shamt = opb[3:0];

    always_comb begin : alu
        case (ex_aluop)
            alu_add: alu_out = ex_src1 + opb;        // wraps mod 2^16
            alu_and: alu_out = ex_src1 & opb;
            alu_not: alu_out = ~ex_src1;
            alu_sll: alu_out = ex_src1 << shamt;
            alu_srl: alu_out = ex_src1 >> shamt;
            alu_sra: alu_out = lc3b_word'($signed(ex_src1) >>> shamt);
            default: alu_out = ex_src1;
        endcase
    end

    assign result = (ex_wbmux_sel == sel_pc_plus_off) ? ex_pc_plus_off : alu_out;

    always_comb begin : cond_codes
        if (!ex_load_cc) begin
            cc = 3'b000;
        end else if (result[$bits(lc3b_word)-1]) begin
            cc = 3'b100;  // n
        end else if (result == '0) begin
            cc = 3'b010;  // z
        end else begin
            cc = 3'b001;  // p
        end
    end

    assign ex_stall = wb_valid && wb_stall;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_valid <= 1'b0;
            wb_dest  <= '0;
            wb_value <= '0;
            wb_cc    <= '0;
        end else if (!ex_stall) begin
            wb_valid <= ex_valid;
            if (ex_valid) begin
                wb_dest  <= ex_dest;
                wb_value <= result;
                wb_cc    <= cc;
            end
        end
    end

endmodule : execute_stage

//--- verilog/instr_receiver.sv
module instr_receiver (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 in_req,
    input  lc3b_types::lc3b_word in_instr,
    input  lc3b_types::lc3b_word in_pc,
    output logic                 in_ack,
    output logic                 buf_valid,
    output lc3b_types::lc3b_word buf_instr,
    output lc3b_types::lc3b_word buf_pc,
    input  logic                 buf_take
);

    typedef enum logic [1:0] {
        st_idle,
        st_hold,
        st_release
    } rx_state_t;

    rx_state_t state;
    logic      capture;

    assign in_ack  = (state == st_hold);
    assign capture = (state == st_idle) && in_req && !buf_valid;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= st_idle;
            buf_valid <= 1'b0;
            buf_instr <= '0;
            buf_pc    <= '0;
        end else begin
            if (capture) begin
                buf_valid <= 1'b1;
                buf_instr <= in_instr;
                buf_pc    <= in_pc;
            end else if (buf_take) begin
                buf_valid <= 1'b0;
            end

            case (state)
                st_idle: begin
                    if (capture) begin
                        state <= st_hold;
                    end
                end
                st_hold: begin
                    if (!in_req) begin  // source let go, drop ack
                        state <= (buf_valid && !buf_take) ? st_release : st_idle;
                    end
                end
                st_release: begin
                    if (!buf_valid || buf_take) begin  // wait for the buffer to drain
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // ack only ever goes up for a word that landed in an empty buffer
    assert property (@(posedge clk) disable iff (!arst_n)
        $rose(in_ack) |-> $past(!buf_valid) && buf_valid);

endmodule : instr_receiver

//--- verilog/issue_stage.sv
`include "lc3b_config.svh"

module issue_stage (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       buf_valid,
    input  lc3b_types::lc3b_word       buf_instr,
    input  lc3b_types::lc3b_word       buf_pc,
    output logic                       buf_take,
    output logic                       ex_valid,
    output lc3b_types::lc3b_aluop      ex_aluop,
    output lc3b_types::lc3b_alumux_sel ex_alumux_sel,
    output lc3b_types::lc3b_wbmux_sel  ex_wbmux_sel,
    output logic                       ex_load_cc,
    output lc3b_types::lc3b_reg        ex_dest,
    output lc3b_types::lc3b_word       ex_src1,
    output lc3b_types::lc3b_word       ex_src2,
    output lc3b_types::lc3b_word       ex_imm,
    output lc3b_types::lc3b_word       ex_pc_plus_off,
    input  logic                       ex_stall,
    input  logic                       wb_valid,
    input  lc3b_types::lc3b_reg        wb_dest,
    input  logic                       rf_we,
    input  lc3b_types::lc3b_reg        rf_waddr,
    input  lc3b_types::lc3b_word       rf_wdata
);

    import lc3b_types::*;

    lc3b_opcode     opcode;
    lc3b_reg        dest;
    lc3b_reg        sr1;
    lc3b_reg        sr2;
    lc3b_word       imm5_sext;
    lc3b_word       off9_sext;
    lc3b_word       rdata1;
    lc3b_word       rdata2;
    lc3b_aluop      aluop;
    lc3b_alumux_sel alumux_sel;
    lc3b_wbmux_sel  wbmux_sel;
    logic           load_regfile;
    logic           load_cc;
    logic           uses_src2;
    logic           hazard;
    logic           ex_free;

    assign opcode    = lc3b_opcode'(buf_instr[15:12]);
    assign dest      = buf_instr[11:9];
    assign sr1       = buf_instr[8:6];
    assign sr2       = buf_instr[2:0];
    assign imm5_sext = {{(`LC3B_WORD_WIDTH-5){buf_instr[4]}}, buf_instr[4:0]};
    assign off9_sext = {{(`LC3B_WORD_WIDTH-9){buf_instr[8]}}, buf_instr[8:0]};

    cpu_control u_control (
        .opcode      (opcode),
        .ir_4        (buf_instr[4]),
        .ir_5        (buf_instr[5]),
        .aluop       (aluop),
        .alumux_sel  (alumux_sel),
        .wbmux_sel   (wbmux_sel),
        .load_regfile(load_regfile),
        .load_cc     (load_cc),
        .uses_src2   (uses_src2)
    );

    regfile u_regfile (
        .clk   (clk),
        .arst_n(arst_n),
        .raddr1(sr1),
        .raddr2(sr2),
        .rdata1(rdata1),
        .rdata2(rdata2),
        .we    (rf_we),
        .waddr (rf_waddr),
        .wdata (rf_wdata)
    );

    // raw interlock against anything not yet committed, no forwarding
    assign hazard = load_regfile &&
        ((ex_valid && (ex_dest == sr1 || (uses_src2 && ex_dest == sr2))) ||
         (wb_valid && (wb_dest == sr1 || (uses_src2 && wb_dest == sr2))));

    assign ex_free  = !ex_valid || !ex_stall;
    assign buf_take = buf_valid && !hazard && (!load_regfile || ex_free);  // drops take no slot

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_valid       <= 1'b0;
            ex_aluop       <= alu_add;
            ex_alumux_sel  <= sel_src2;
            ex_wbmux_sel   <= sel_alu_out;
            ex_load_cc     <= 1'b0;
            ex_dest        <= '0;
            ex_src1        <= '0;
            ex_src2        <= '0;
            ex_imm         <= '0;
            ex_pc_plus_off <= '0;
        end else if (ex_free) begin
            ex_valid <= buf_take && load_regfile;
            if (buf_take && load_regfile) begin
                ex_aluop       <= aluop;
                ex_alumux_sel  <= alumux_sel;
                ex_wbmux_sel   <= wbmux_sel;
                ex_load_cc     <= load_cc;
                ex_dest        <= dest;
                ex_src1        <= rdata1;
                ex_src2        <= rdata2;
                ex_imm         <= imm5_sext;              // imm4 is its low nibble
                ex_pc_plus_off <= buf_pc + (off9_sext << 1);
            end
        end
    end

    assert property (@(posedge clk) disable iff (!arst_n)
        ex_valid && ex_stall |=> ex_valid && $stable(ex_dest) &&
                                 $stable(ex_src1) && $stable(ex_src2));

endmodule : issue_stage

//--- verilog/lc3b_config.svh
`ifndef LC3B_CONFIG_SVH
`define LC3B_CONFIG_SVH

`define LC3B_WORD_WIDTH 16  // data and instruction width
`define LC3B_NUM_REGS   8   // architectural registers r0..r7
`define LC3B_REG_BITS   3   // register index width

`endif

//--- verilog/lc3b_core.sv
module lc3b_core (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 in_req,
    input  lc3b_types::lc3b_word in_instr,
    input  lc3b_types::lc3b_word in_pc,
    output logic                 in_ack,
    output logic                 out_req,
    input  logic                 out_ack,
    output lc3b_types::lc3b_reg  out_dest,
    output lc3b_types::lc3b_word out_value,
    output logic [2:0]           out_cc
);

    import lc3b_types::*;

    logic           buf_valid;
    lc3b_word       buf_instr;
    lc3b_word       buf_pc;
    logic           buf_take;
    logic           ex_valid;
    lc3b_aluop      ex_aluop;
    lc3b_alumux_sel ex_alumux_sel;
    lc3b_wbmux_sel  ex_wbmux_sel;
    logic           ex_load_cc;
    lc3b_reg        ex_dest;
    lc3b_word       ex_src1;
    lc3b_word       ex_src2;
    lc3b_word       ex_imm;
    lc3b_word       ex_pc_plus_off;
    logic           ex_stall;
    logic           wb_valid;
    lc3b_reg        wb_dest;
    lc3b_word       wb_value;
    logic [2:0]     wb_cc;
    logic           wb_stall;
    logic           rf_we;
    lc3b_reg        rf_waddr;
    lc3b_word       rf_wdata;

    instr_receiver u_receiver (
        .clk      (clk),
        .arst_n   (arst_n),
        .in_req   (in_req),
        .in_instr (in_instr),
        .in_pc    (in_pc),
        .in_ack   (in_ack),
        .buf_valid(buf_valid),
        .buf_instr(buf_instr),
        .buf_pc   (buf_pc),
        .buf_take (buf_take)
    );

    // holds the register file, written back from the sender
    issue_stage u_issue (
        .clk           (clk),
        .arst_n        (arst_n),
        .buf_valid     (buf_valid),
        .buf_instr     (buf_instr),
        .buf_pc        (buf_pc),
        .buf_take      (buf_take),
        .ex_valid      (ex_valid),
        .ex_aluop      (ex_aluop),
        .ex_alumux_sel (ex_alumux_sel),
        .ex_wbmux_sel  (ex_wbmux_sel),
        .ex_load_cc    (ex_load_cc),
        .ex_dest       (ex_dest),
        .ex_src1       (ex_src1),
        .ex_src2       (ex_src2),
        .ex_imm        (ex_imm),
        .ex_pc_plus_off(ex_pc_plus_off),
        .ex_stall      (ex_stall),
        .wb_valid      (wb_valid),
        .wb_dest       (wb_dest),
        .rf_we         (rf_we),
        .rf_waddr      (rf_waddr),
        .rf_wdata      (rf_wdata)
    );

    execute_stage u_execute (
        .clk           (clk),
        .arst_n        (arst_n),
        .ex_valid      (ex_valid),
        .ex_aluop      (ex_aluop),
        .ex_alumux_sel (ex_alumux_sel),
        .ex_wbmux_sel  (ex_wbmux_sel),
        .ex_load_cc    (ex_load_cc),
        .ex_dest       (ex_dest),
        .ex_src1       (ex_src1),
        .ex_src2       (ex_src2),
        .ex_imm        (ex_imm),
        .ex_pc_plus_off(ex_pc_plus_off),
        .ex_stall      (ex_stall),
        .wb_valid      (wb_valid),
        .wb_dest       (wb_dest),
        .wb_value      (wb_value),
        .wb_cc         (wb_cc),
        .wb_stall      (wb_stall)
    );

    writeback_sender u_sender (
        .clk      (clk),
        .arst_n   (arst_n),
        .wb_valid (wb_valid),
        .wb_dest  (wb_dest),
        .wb_value (wb_value),
        .wb_cc    (wb_cc),
        .wb_stall (wb_stall),
        .out_req  (out_req),
        .out_ack  (out_ack),
        .out_dest (out_dest),
        .out_value(out_value),
        .out_cc   (out_cc),
        .rf_we    (rf_we),
        .rf_waddr (rf_waddr),
        .rf_wdata (rf_wdata)
    );

endmodule : lc3b_core

//--- verilog/lc3b_types.sv
`include "lc3b_config.svh"

package lc3b_types;

    typedef logic [`LC3B_WORD_WIDTH-1:0] lc3b_word;
    typedef logic [`LC3B_REG_BITS-1:0]   lc3b_reg;

    // standard lc-3b opcode encodings
    typedef enum logic [3:0] {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_ldb  = 4'b0010,
        op_stb  = 4'b0011,
        op_jsr  = 4'b0100,
        op_and  = 4'b0101,
        op_ldr  = 4'b0110,
        op_str  = 4'b0111,
        op_rti  = 4'b1000,
        op_not  = 4'b1001,
        op_ldi  = 4'b1010,
        op_sti  = 4'b1011,
        op_jmp  = 4'b1100,
        op_shf  = 4'b1101,
        op_lea  = 4'b1110,
        op_trap = 4'b1111
    } lc3b_opcode;

    typedef enum logic [2:0] {
        alu_add,
        alu_and,
        alu_not,
        alu_pass,
        alu_sll,
        alu_srl,
        alu_sra
    } lc3b_aluop;

    typedef enum logic [1:0] {
        sel_src2,
        sel_imm4,
        sel_imm5
    } lc3b_alumux_sel;

    typedef enum logic {
        sel_alu_out,
        sel_pc_plus_off
    } lc3b_wbmux_sel;

endpackage : lc3b_types

//--- verilog/regfile.sv
`include "lc3b_config.svh"

module regfile (
    input  logic                 clk,
    input  logic                 arst_n,
    input  lc3b_types::lc3b_reg  raddr1,
    input  lc3b_types::lc3b_reg  raddr2,
    output lc3b_types::lc3b_word rdata1,
    output lc3b_types::lc3b_word rdata2,
    input  logic                 we,
    input  lc3b_types::lc3b_reg  waddr,
    input  lc3b_types::lc3b_word wdata
);

    import lc3b_types::*;

    lc3b_word regs [`LC3B_NUM_REGS];

    // no bypass, new value shows up the cycle after the write
    assign rdata1 = regs[raddr1];
    assign rdata2 = regs[raddr2];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `LC3B_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

endmodule : regfile

//--- verilog/writeback_sender.sv
module writeback_sender (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 wb_valid,
    input  lc3b_types::lc3b_reg  wb_dest,
    input  lc3b_types::lc3b_word wb_value,
    input  logic [2:0]           wb_cc,
    output logic                 wb_stall,
    output logic                 out_req,
    input  logic                 out_ack,
    output lc3b_types::lc3b_reg  out_dest,
    output lc3b_types::lc3b_word out_value,
    output logic [2:0]           out_cc,
    output logic                 rf_we,
    output lc3b_types::lc3b_reg  rf_waddr,
    output lc3b_types::lc3b_word rf_wdata
);

    typedef enum logic [1:0] {
        st_idle,
        st_wait_ack_high,
        st_wait_ack_low
    } tx_state_t;

    tx_state_t state;

    // payload stays in the execute/write-back register until the entry frees
    assign out_req   = (state == st_wait_ack_high);
    assign out_dest  = wb_dest;
    assign out_value = wb_value;
    assign out_cc    = wb_cc;

    assign rf_we    = out_req && out_ack;  // once, on the first ack high
    assign rf_waddr = wb_dest;
    assign rf_wdata = wb_value;

    assign wb_stall = wb_valid && !(state == st_wait_ack_low && !out_ack);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (wb_valid) begin
                        state <= st_wait_ack_high;
                    end
                end
                st_wait_ack_high: begin
                    if (out_ack) begin
                        state <= st_wait_ack_low;
                    end
                end
                st_wait_ack_low: begin
                    if (!out_ack) begin  // retire, execute may refill now
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (!arst_n)
        out_req |=> !out_req || ($stable(out_value) && $stable(out_dest)));

endmodule : writeback_sender
